// File: Bender.yml
package:
  name: sonar

sources:
  - files:
      - hdl/sonar_pkg.sv
      - hdl/sonar_timebase.sv
      - hdl/sonar_trigger.sv
      - hdl/echo_timer.sv
      - hdl/range_converter.sv
      - hdl/proximity_guard.sv
      - hdl/sonar_top.sv
  - target: test
    files:
      - dv/sonar_tb.sv

// File: all.f
hdl/sonar_pkg.sv
hdl/sonar_timebase.sv
hdl/sonar_trigger.sv
hdl/echo_timer.sv
hdl/range_converter.sv
hdl/proximity_guard.sv
hdl/sonar_top.sv
dv/sonar_tb.sv

// File: dv/sonar_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sonar_tb;

    localparam int CLK_PER_US  = 4;
    localparam int TRIG_US     = 3;
    localparam int PERIOD_US   = 200;
    localparam int MAX_ECHO_US = 150;
    localparam int NEAR_MM     = 8;
    localparam int FAR_MM      = 15;
    localparam int W           = sonar_pkg::WIDTH_BITS;
    localparam int TRIG_CLKS   = TRIG_US * CLK_PER_US;
    localparam int PERIOD_CLKS = PERIOD_US * CLK_PER_US;
    localparam int N_RANDOM    = 8;
    localparam int N_PERIODS   = 30;  // About one period per echo and two for the held one
    localparam int LIMIT       = N_PERIODS * PERIOD_CLKS + 2000;

    localparam logic [W-1:0] NEAR_THR = W'(NEAR_MM);
    localparam logic [W-1:0] FAR_THR  = W'(FAR_MM);
    localparam logic [W-1:0] CAP_MM   =
        W'(MAX_ECHO_US * sonar_pkg::US_TO_MM_NUM / sonar_pkg::US_TO_MM_DEN);

    logic              clk;
    logic              rst;
    logic              echo;
    logic              thres_sel;
    logic              trig;
    logic              stop;
    logic              range_valid;
    sonar_pkg::range_t range;

    logic [W-1:0] dist_lo = '0;
    logic [W-1:0] dist_hi = '0;
    logic         exp_timeout = 1'b0;
    logic         stop_exp = 1'b0;
    logic         stop_exp_q = 1'b0;
    logic         held_result = 1'b0;
    logic         trig_q = 1'b0;
    logic         seen_rise = 1'b0;
    int           high_len = 0;
    int           since_rise = 0;
    int           rst_cycles = 0;
    int           n_results = 0;
    int           err_count = 0;
    int           err_mark = 0;
    int           n_tests = 0;
    int           n_failed = 0;
    int           cycles = 0;
    int unsigned  fixed_w [6] = '{20, 30, 70, 100, 60, 12};

    sonar_top #(
        .CLK_PER_US (CLK_PER_US),
        .TRIG_US    (TRIG_US),
        .PERIOD_US  (PERIOD_US),
        .MAX_ECHO_US(MAX_ECHO_US),
        .NEAR_MM    (NEAR_MM),
        .FAR_MM     (FAR_MM)
    ) i_sonar_top (
        .clk        (clk),
        .rst        (rst),
        .echo       (echo),
        .thres_sel  (thres_sel),
        .trig       (trig),
        .stop       (stop),
        .range_valid(range_valid),
        .range      (range)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [W-1:0] us_to_mm(input int unsigned w);
        return W'(w * sonar_pkg::US_TO_MM_NUM / sonar_pkg::US_TO_MM_DEN);
    endfunction

    function automatic bit near_threshold(input int unsigned w);
        int mm;
        mm = int'(us_to_mm(w));
        return (mm >= NEAR_MM - 1 && mm <= NEAR_MM + 1) || (mm >= FAR_MM - 1 && mm <= FAR_MM + 1);
    endfunction

    task automatic log_error(input string msg);
        $display("%s", msg);
        err_count++;
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        if (err_count != err_mark) begin
            n_failed++;
            $display("Test %s: FAIL with %0d errors", name, err_count - err_mark);
        end else begin
            $display("Test %s: ok", name);
        end
        err_mark = err_count;
    endtask

    // Sensor model, answers each trigger with one echo of w microseconds
    task automatic ping(input int unsigned w, input logic sel);
        int n_start;
        int waited;
        n_start = n_results;
        do @(posedge clk); while (!trig);
        thres_sel <= sel;
        do @(posedge clk); while (trig);
        repeat (3) @(posedge clk);
        exp_timeout <= (w > MAX_ECHO_US);
        dist_lo     <= us_to_mm(w - 1);
        dist_hi     <= us_to_mm(w + 1);
        stop_exp    <= (w <= MAX_ECHO_US) && (us_to_mm(w) < (sel ? FAR_THR : NEAR_THR));
        echo        <= 1'b1;
        repeat (w * CLK_PER_US) @(posedge clk);
        echo   <= 1'b0;
        waited = 0;
        while (n_results == n_start && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        repeat (8) @(posedge clk);  // Leaves room for a stray second result
        a_one_result: assert (n_results == n_start + 1)
            else log_error($sformatf("Echo of %0d us gave %0d results instead of one",
                                     w, n_results - n_start));
    endtask

    always @(posedge clk) begin
        rst_cycles <= rst ? rst_cycles + 1 : 0;
        trig_q     <= trig;
        if (range_valid) begin
            n_results <= n_results + 1;
        end
        if (rst) begin
            high_len    <= 0;
            since_rise  <= 0;
            seen_rise   <= 1'b0;
            stop_exp_q  <= 1'b0;
            held_result <= 1'b0;
        end else begin
            high_len <= trig ? high_len + 1 : 0;
            if (trig && !trig_q) begin
                since_rise <= 1;
                seen_rise  <= 1'b1;
            end else begin
                since_rise <= since_rise + 1;
            end
            if (range_valid) begin
                stop_exp_q <= stop_exp;
            end
            if (!echo) begin
                held_result <= 1'b0;  // A new echo may end normally again
            end else if (range_valid && range.timeout) begin
                held_result <= 1'b1;
            end
        end
    end

    a_reset_clear: assert property (@(posedge clk) rst && rst_cycles != 0 |->
        !trig && !range_valid && !stop && range == '0)
        else log_error($sformatf("ERR reset state trig %h range_valid %h stop %h range %h",
            $sampled(trig), $sampled(range_valid), $sampled(stop), $sampled(range)));

    a_trig_first: assert property (@(posedge clk) disable iff (rst)
        $rose(trig) && !seen_rise |-> since_rise >= CLK_PER_US)
        else log_error($sformatf("trig rose only %0d clocks after reset", $sampled(since_rise)));

    a_trig_width: assert property (@(posedge clk) disable iff (rst)
        $fell(trig) |-> high_len >= TRIG_CLKS - CLK_PER_US && high_len <= TRIG_CLKS + CLK_PER_US)
        else log_error($sformatf("ERR trig high clocks %h expected %h", $sampled(high_len),
                                 TRIG_CLKS));

    a_trig_period: assert property (@(posedge clk) disable iff (rst)
        $rose(trig) && seen_rise |-> since_rise == PERIOD_CLKS)
        else log_error($sformatf("ERR trig period clocks %h expected %h", $sampled(since_rise),
                                 PERIOD_CLKS));

    a_dist: assert property (@(posedge clk) disable iff (rst)
        range_valid && !range.timeout |-> range.dist_mm >= dist_lo && range.dist_mm <= dist_hi)
        else log_error($sformatf("ERR range.dist_mm %h expected %h to %h",
                                 $sampled(range.dist_mm), dist_lo, dist_hi));

    a_timeout_flag: assert property (@(posedge clk) disable iff (rst)
        range_valid |-> range.timeout == exp_timeout)
        else log_error($sformatf("ERR range.timeout %h expected %h", $sampled(range.timeout),
                                 exp_timeout));

    a_cap_dist: assert property (@(posedge clk) disable iff (rst)
        range_valid && range.timeout |-> range.dist_mm == CAP_MM)
        else log_error($sformatf("ERR range.dist_mm %h expected %h", $sampled(range.dist_mm),
                                 CAP_MM));

    a_held_echo: assert property (@(posedge clk) disable iff (rst)
        range_valid |-> !held_result)
        else log_error("Second result arrived while a timed-out echo was still high");

    a_stop: assert property (@(posedge clk) disable iff (rst) stop == stop_exp_q)
        else log_error($sformatf("ERR stop %h expected %h", $sampled(stop),
                                 $sampled(stop_exp_q)));

    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d clocks, the tests did not finish", LIMIT);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int unsigned w;
        void'($urandom(32'hd4b8));
        rst       = 1'b1;
        echo      = 1'b0;
        thres_sel = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        foreach (fixed_w[i]) begin
            ping(fixed_w[i], i % 2 == 1);
        end
        finish_test("trigger and fixed widths");

        ping(30, 1'b0);
        ping(170, 1'b0);  // Capped at MAX_ECHO_US, clears the stop raised before
        ping(350, 1'b1);  // Held high across a whole trigger period
        ping(25, 1'b1);
        finish_test("timeout");

        for (int i = 0; i < N_RANDOM; i++) begin
            w = $urandom_range(140, 5);
            while (near_threshold(w)) begin
                w = $urandom_range(140, 5);
            end
            ping(w, $urandom_range(1, 0) == 1);
        end
        finish_test("random widths");

        ping(20, 1'b0);
        do @(posedge clk); while (!trig);  // Reset lands while trig and stop are both high
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        ping(40, 1'b1);
        ping(110, 1'b0);
        finish_test("reset mid-run");

        $display("Tests run %0d, failed %0d, errors %0d", n_tests, n_failed, err_count);
        if (err_count == 0 && n_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/echo_timer.sv
`timescale 1ns/1ps
`default_nettype none

module echo_timer #(
    parameter int MAX_ECHO_US = 30000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 us_tick,
    input  logic                 echo,
    output logic                 meas_valid,
    output sonar_pkg::echo_meas_t meas
);

    localparam int W = sonar_pkg::WIDTH_BITS;
    localparam logic [W-1:0] CNT_LAST = W'(MAX_ECHO_US - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COUNT,
        ST_WAIT_LOW
    } state_t;

    state_t        state;
    logic [1:0]    echo_sync;
    logic          echo_prev;
    logic [W-1:0]  cnt;
    logic          rise;
    logic          fall;
    logic          end_fall;
    logic          end_cap;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            echo_sync <= '0;
            echo_prev <= 1'b0;
        end else begin
            echo_sync <= {echo_sync[0], echo};  // echo is not related to clk
            echo_prev <= echo_sync[1];
        end
    end

    assign rise = echo_sync[1] & ~echo_prev;
    assign fall = ~echo_sync[1] & echo_prev;

    assign end_fall = (state == ST_COUNT) && fall;
    assign end_cap  = (state == ST_COUNT) && !fall && us_tick && (cnt == CNT_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            cnt        <= '0;
            meas_valid <= 1'b0;
        end else begin
            meas_valid <= end_fall | end_cap;
            case (state)
                ST_IDLE: begin
                    if (rise) begin
                        cnt   <= '0;
                        state <= ST_COUNT;
                    end
                end
                ST_COUNT: begin
                    if (end_fall) begin
                        state <= ST_IDLE;
                    end else if (us_tick) begin
                        cnt <= cnt + 1'b1;
                        if (end_cap) begin
                            state <= ST_WAIT_LOW;  // Ignore the rest of a runaway echo
                        end
                    end
                end
                ST_WAIT_LOW: begin
                    if (!echo_sync[1]) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (end_fall) begin
            meas.width_us <= cnt;
            meas.timeout  <= 1'b0;
        end else if (end_cap) begin
            meas.width_us <= cnt + 1'b1;  // Saturated at MAX_ECHO_US
            meas.timeout  <= 1'b1;
        end
    end

    // A finished echo must leave through idle before the next one ends
    a_meas_single: assert property (
        @(posedge clk) disable iff (rst)
        meas_valid |=> !meas_valid
    ) else $error("meas_valid high on two consecutive clocks");

endmodule

`default_nettype wire

// File: hdl/proximity_guard.sv
`timescale 1ns/1ps
`default_nettype none

module proximity_guard #(
    parameter int NEAR_MM = 250,
    parameter int FAR_MM  = 400
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              thres_sel,
    input  logic              range_valid,
    input  sonar_pkg::range_t range,
    output logic              stop
);

    localparam int W = sonar_pkg::WIDTH_BITS;
    localparam logic [W-1:0] NEAR_THR = W'(NEAR_MM);
    localparam logic [W-1:0] FAR_THR  = W'(FAR_MM);

    logic [W-1:0] thr;

    if (NEAR_MM >= FAR_MM) begin : g_bad_thresholds
        $error("proximity_guard needs NEAR_MM below FAR_MM");
    end

    assign thr = thres_sel ? FAR_THR : NEAR_THR;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stop <= 1'b0;
        end else if (range_valid) begin
            // A lost echo tells nothing about an obstacle
            stop <= (range.dist_mm < thr) && !range.timeout;
        end
    end

endmodule

`default_nettype wire

// File: hdl/range_converter.sv
`timescale 1ns/1ps
`default_nettype none

module range_converter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  meas_valid,
    input  sonar_pkg::echo_meas_t meas,
    output logic                  range_valid,
    output sonar_pkg::range_t     range
);

    localparam int W      = sonar_pkg::WIDTH_BITS;
    localparam int PROD_W = W + $clog2(sonar_pkg::US_TO_MM_NUM);

    localparam logic [PROD_W-1:0] NUM = PROD_W'(sonar_pkg::US_TO_MM_NUM);
    localparam logic [PROD_W-1:0] DEN = PROD_W'(sonar_pkg::US_TO_MM_DEN);

    logic              s1_valid;
    logic [PROD_W-1:0] s1_prod;
    logic              s1_timeout;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid    <= 1'b0;
            range_valid <= 1'b0;
            range       <= '0;
        end else begin
            s1_valid    <= meas_valid;
            range_valid <= s1_valid;
            if (s1_valid) begin
                range.dist_mm <= W'(s1_prod / DEN);  // Floor division
                range.timeout <= s1_timeout;
            end
        end
    end

    // Scaling is done a stage ahead so the divider sees a registered operand
    always_ff @(posedge clk) begin
        if (meas_valid) begin
            s1_prod    <= PROD_W'(meas.width_us) * NUM;
            s1_timeout <= meas.timeout;
        end
    end

endmodule

`default_nettype wire

// File: hdl/sonar_pkg.sv
`default_nettype none

package sonar_pkg;

    // Echo time and distance share one field width
    localparam int unsigned WIDTH_BITS = 20;

    // Sound travels about 10 mm in 58 us of round trip
    localparam int unsigned US_TO_MM_NUM = 10;
    localparam int unsigned US_TO_MM_DEN = 58;

    // One finished echo from the timer
    typedef struct packed {
        logic [WIDTH_BITS-1:0] width_us;  // High time of the echo line
        logic                  timeout;   // Echo hit the cap or never fell
    } echo_meas_t;

    // One converted distance
    typedef struct packed {
        logic [WIDTH_BITS-1:0] dist_mm;
        logic                  timeout;   // Carried over from the measurement
    } range_t;

endpackage

`default_nettype wire

// File: hdl/sonar_timebase.sv
`timescale 1ns/1ps
`default_nettype none

module sonar_timebase #(
    parameter int CLK_PER_US = 100
) (
    input  logic clk,
    input  logic rst,
    output logic us_tick
);

    localparam int CW = $clog2(CLK_PER_US);
    localparam logic [CW-1:0] CNT_LAST = CW'(CLK_PER_US - 1);

    logic [CW-1:0] cnt;

    // A single clock per microsecond would leave no room for a one-clock strobe
    if (CLK_PER_US < 2) begin : g_bad_clk_per_us
        $error("sonar_timebase needs CLK_PER_US of at least 2");
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            us_tick <= 1'b0;
        end else begin
            if (cnt == CNT_LAST) begin
                cnt     <= '0;
                us_tick <= 1'b1;  // First strobe lands CLK_PER_US clocks after reset
            end else begin
                cnt     <= cnt + 1'b1;
                us_tick <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/sonar_top.sv
`timescale 1ns/1ps
`default_nettype none

module sonar_top #(
    parameter int CLK_PER_US  = 100,
    parameter int TRIG_US     = 10,
    parameter int PERIOD_US   = 100000,
    parameter int MAX_ECHO_US = 30000,
    parameter int NEAR_MM     = 250,
    parameter int FAR_MM      = 400
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              echo,
    input  logic              thres_sel,  // 0 picks NEAR_MM, 1 picks FAR_MM
    output logic              trig,
    output logic              stop,
    output logic              range_valid,
    output sonar_pkg::range_t range
);

    logic                  us_tick;
    logic                  meas_valid;
    sonar_pkg::echo_meas_t meas;

    sonar_timebase #(
        .CLK_PER_US(CLK_PER_US)
    ) i_sonar_timebase (
        .clk    (clk),
        .rst    (rst),
        .us_tick(us_tick)
    );

    sonar_trigger #(
        .CLK_PER_US(CLK_PER_US),
        .TRIG_US   (TRIG_US),
        .PERIOD_US (PERIOD_US)
    ) i_sonar_trigger (
        .clk    (clk),
        .rst    (rst),
        .us_tick(us_tick),
        .trig   (trig)
    );

    echo_timer #(
        .MAX_ECHO_US(MAX_ECHO_US)
    ) i_echo_timer (
        .clk       (clk),
        .rst       (rst),
        .us_tick   (us_tick),
        .echo      (echo),
        .meas_valid(meas_valid),
        .meas      (meas)
    );

    range_converter i_range_converter (
        .clk        (clk),
        .rst        (rst),
        .meas_valid (meas_valid),
        .meas       (meas),
        .range_valid(range_valid),
        .range      (range)
    );

    proximity_guard #(
        .NEAR_MM(NEAR_MM),
        .FAR_MM (FAR_MM)
    ) i_proximity_guard (
        .clk        (clk),
        .rst        (rst),
        .thres_sel  (thres_sel),
        .range_valid(range_valid),
        .range      (range),
        .stop       (stop)
    );

endmodule

`default_nettype wire

// File: hdl/sonar_trigger.sv
`timescale 1ns/1ps
`default_nettype none

module sonar_trigger #(
    parameter int CLK_PER_US = 100,
    parameter int TRIG_US    = 10,
    parameter int PERIOD_US  = 100000
) (
    input  logic clk,
    input  logic rst,
    input  logic us_tick,
    output logic trig
);

    localparam int CW        = $clog2(PERIOD_US);
    localparam int TRIG_CLKS = TRIG_US * CLK_PER_US;

    localparam logic [CW-1:0] CNT_LAST = CW'(PERIOD_US - 1);
    localparam logic [CW-1:0] CNT_FALL = CW'(TRIG_US);

    logic [CW-1:0] cnt;  // Microseconds since the last trigger rise

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            trig <= 1'b0;
        end else if (us_tick) begin
            if (cnt == CNT_LAST) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end

            if (cnt == '0) begin
                trig <= 1'b1;  // Start of a new ranging period
            end else if (cnt == CNT_FALL) begin
                trig <= 1'b0;
            end
        end
    end

    // The sensor wants a short pulse, a stuck trigger would stall ranging
    a_trig_width: assert property (
        @(posedge clk) disable iff (rst)
        $rose(trig) |-> ##[1:TRIG_CLKS] !trig
    ) else $error("trig held high beyond %0d clocks", TRIG_CLKS);

endmodule

`default_nettype wire
